// File: build.f
rtl/isaPkg.sv
rtl/corePkg.sv
rtl/controlDecode.sv
rtl/alu.sv
rtl/executeInstruction.sv
rtl/registerFile.sv
rtl/coreSequencer.sv
rtl/cpuCore.sv
verification/cpuCore_props.sv
verification/cpuCore_tb.sv

// File: run.sh
#!/bin/sh
# Compile with Verilator, run the testbench, then look for the pass line in the log
rm -f build.log sim.log
verilator --binary --assert --top-module cpuCore_tb -f build.f -Mdir obj_dir \
	-o cpuCore_sim > build.log 2>&1 \
	&& ./obj_dir/cpuCore_sim > sim.log 2>&1
cat build.log
[ -f sim.log ] && cat sim.log
grep -q "^Simulation passed$" sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }

// File: verification/cpuCore_tb.sv
// Testbench for the multicycle execute core
// Random instruction stream from an LFSR, checked against a register and pc model
`timescale 1ns/1ps
`default_nettype none

module cpuCore_tb
	import isaPkg::*;
;

	localparam int doneTimeout = 20;

	logic        clk;
	logic        reset;
	logic        start;
	logic [15:0] instr;
	logic [15:0] pc;
	logic        busy;
	logic        done;
	logic        wbEn;
	logic [2:0]  wbReg;
	logic [15:0] wbData;

	// Reference state
	logic [15:0] mregs [8];
	logic [15:0] mpc;
	logic [15:0] lfsrState;

	int errorCount;
	int testErrors;
	int testsRun;
	int testsFailed;

	cpuCore cpuCore_inst (
		.clk(clk),
		.reset(reset),
		.start(start),
		.instr(instr),
		.pc(pc),
		.busy(busy),
		.done(done),
		.wbEn(wbEn),
		.wbReg(wbReg),
		.wbData(wbData)
	);

	// Strobe checks live inside the sequencer
	bind coreSequencer cpuCore_props props (
		.clk(clk),
		.reset(reset),
		.latchInstr(latchInstr),
		.latchOperands(latchOperands),
		.latchResult(latchResult),
		.commit(commit),
		.busy(busy),
		.done(done)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// 16-bit Galois LFSR, maximal length taps
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
	endfunction

	// One LFSR step per bit taken
	function automatic logic [15:0] nextRand(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrStep(lfsrState);
			v = {v[14:0], lfsrState[0]};
		end
		return v;
	endfunction

	task automatic checkValue(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (expected !== actual) begin
			errorCount++;
			testErrors++;
			$display("ERROR t=%0t %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	task automatic beginTest();
		testErrors = 0;
	endtask

	task automatic endTest(input string name);
		testsRun++;
		if (testErrors == 0) begin
			$display("test %s: ok", name);
		end else begin
			testsFailed++;
			$display("test %s: FAILED with %0d errors", name, testErrors);
		end
	endtask

	// Opcode by kind, low 11 bits fully random
	// Kind 0 ALU and LBI, 1 branch, 2 jump, else NOP
	task automatic randWord(input int kind, output logic [15:0] w);
		logic [15:0] k;
		logic [15:0] r;
		logic [4:0]  op;
		k = nextRand(3);
		r = nextRand(11);
		case (kind)
			0: begin
				case (k[2:0])
					3'd0:    op = opAddi;
					3'd1:    op = opSubi;
					3'd2:    op = opXori;
					3'd3:    op = opAndni;
					3'd4:    op = opLbi;
					default: op = opRType;
				endcase
			end
			// BEQZ BNEZ BLTZ BGEZ
			1: op = {3'b011, k[1:0]};
			// J JR JAL JALR
			2: op = {3'b001, k[1:0]};
			default: op = opNop;
		endcase
		w = {op, r[10:0]};
	endtask

	// Executes one instruction on the model, returns the expected writeback
	task automatic modelExec(input logic [15:0] w, output logic expEn,
		output logic [2:0] expReg, output logic [15:0] expData);
		logic [4:0]  op;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] s5;
		logic [15:0] z5;
		logic [15:0] s8;
		logic [15:0] s11;
		logic [15:0] link;
		logic [15:0] pcNext;
		op = w[15:11];
		a = mregs[w[10:8]];
		b = mregs[w[7:5]];
		s5 = {{11{w[4]}}, w[4:0]};
		z5 = {11'b0, w[4:0]};
		s8 = {{8{w[7]}}, w[7:0]};
		s11 = {{5{w[10]}}, w[10:0]};
		link = mpc + 16'd2;
		pcNext = link;
		expEn = 1'b0;
		expReg = w[7:5];
		expData = 16'h0000;
		case (op)
			opAddi: begin
				expEn = 1'b1;
				expData = a + s5;
			end
			opSubi: begin
				expEn = 1'b1;
				expData = s5 - a;
			end
			opXori: begin
				expEn = 1'b1;
				expData = a ^ z5;
			end
			opAndni: begin
				expEn = 1'b1;
				expData = a & ~z5;
			end
			opLbi: begin
				expEn = 1'b1;
				expReg = w[10:8];
				expData = s8;
			end
			opRType: begin
				expEn = 1'b1;
				expReg = w[4:2];
				case (w[1:0])
					2'b00:   expData = a + b;
					2'b01:   expData = b - a;
					2'b10:   expData = a ^ b;
					default: expData = a & ~b;
				endcase
			end
			opBeqz: if (a == 16'h0000) pcNext = link + s8;
			opBnez: if (a != 16'h0000) pcNext = link + s8;
			opBltz: if (a[15]) pcNext = link + s8;
			opBgez: if (!a[15]) pcNext = link + s8;
			opJ: pcNext = link + s11;
			opJal: begin
				pcNext = link + s11;
				expEn = 1'b1;
				expReg = 3'd7;
				expData = link;
			end
			opJr: pcNext = a + s8;
			opJalr: begin
				pcNext = a + s8;
				expEn = 1'b1;
				expReg = 3'd7;
				expData = link;
			end
			default: begin
				// NOP changes only pc
			end
		endcase
		if (expEn) begin
			mregs[expReg] = expData;
		end
		mpc = pcNext;
	endtask

	// Called on a falling edge with the core idle, returns on the done edge
	task automatic issue(input logic [15:0] w);
		logic        expEn;
		logic [2:0]  expReg;
		logic [15:0] expData;
		int          n;
		modelExec(w, expEn, expReg, expData);
		start = 1'b1;
		instr = w;
		@(negedge clk);
		start = 1'b0;
		n = 1;
		while (!done && n < doneTimeout) begin
			@(negedge clk);
			n++;
		end
		if (!done) begin
			$display("Timeout: no done within %0d cycles for instruction %h", doneTimeout, w);
			errorCount++;
			testErrors++;
		end else begin
			// Acceptance edge is one cycle after the driving edge
			checkValue("latency", 16'd3, 16'(n - 1));
			checkValue("wbEn", 16'(expEn), 16'(wbEn));
			if (expEn) begin
				checkValue("wbReg", 16'(expReg), 16'(wbReg));
				checkValue("wbData", expData, wbData);
			end
			checkValue("pc", mpc, pc);
		end
	endtask

	initial begin
		logic [15:0] w;
		logic [15:0] r;
		logic [15:0] pcBefore;
		logic [15:0] expected;
		logic        expEn;
		logic [2:0]  expReg;
		logic [15:0] expData;
		int          doneCount;

		reset = 1'b1;
		start = 1'b0;
		instr = 16'h0000;
		lfsrState = 16'd78;
		mpc = 16'h0000;
		for (int i = 0; i < 8; i++) begin
			mregs[i] = 16'h0000;
		end
		errorCount = 0;
		testsRun = 0;
		testsFailed = 0;

		repeat (10) @(negedge clk);
		reset = 1'b0;

		beginTest();
		@(negedge clk);
		checkValue("pc", 16'h0000, pc);
		checkValue("busy", 16'd0, 16'(busy));
		checkValue("done", 16'd0, 16'(done));
		checkValue("wbEn", 16'd0, 16'(wbEn));
		endTest("reset");

		beginTest();
		issue({opNop, 11'd0});
		@(negedge clk);
		checkValue("done", 16'd0, 16'(done));
		// Second start lands in decode and must be dropped
		w = {opNop, 11'd0};
		modelExec(w, expEn, expReg, expData);
		start = 1'b1;
		instr = w;
		@(negedge clk);
		checkValue("busy", 16'd1, 16'(busy));
		instr = {opLbi, 3'd1, 8'h5A};
		@(negedge clk);
		start = 1'b0;
		doneCount = 0;
		repeat (10) begin
			if (done) doneCount++;
			@(negedge clk);
		end
		checkValue("doneCount", 16'd1, 16'(doneCount));
		checkValue("pc", mpc, pc);
		endTest("latency");

		beginTest();
		for (int i = 0; i < 200; i++) begin
			randWord(0, w);
			pcBefore = mpc;
			issue(w);
			checkValue("pc", pcBefore + 16'd2, pc);
		end
		endTest("alu");

		beginTest();
		for (int i = 0; i < 100; i++) begin
			// Load a value into the tested register, zero now and then
			r = nextRand(13);
			w = {opLbi, r[10:0]};
			if (r[12:11] == 2'b00) begin
				w[7:0] = 8'h00;
			end
			issue(w);
			r = nextRand(10);
			issue({3'b011, r[9:8], w[10:8], r[7:0]});
		end
		endTest("branch");

		beginTest();
		for (int i = 0; i < 60; i++) begin
			randWord(2, w);
			issue(w);
		end
		endTest("jump");

		beginTest();
		for (int i = 0; i < 300; i++) begin
			r = nextRand(2);
			randWord(int'(r[1:0]), w);
			issue(w);
		end
		// ADDI with zero immediate reads each register back
		for (int i = 0; i < 8; i++) begin
			expected = mregs[i];
			issue({opAddi, 3'(i), 3'(i), 5'd0});
			checkValue("regRead", expected, wbData);
		end
		endTest("state");

		$display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
		if (errorCount == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/cpuCore_props.sv
// Sequencer strobe properties
// Bound into coreSequencer, checks done width and strobe exclusivity
`timescale 1ns/1ps
`default_nettype none

module cpuCore_props (
	input logic clk,
	input logic reset,
	input logic latchInstr,
	input logic latchOperands,
	input logic latchResult,
	input logic commit,
	input logic busy,
	input logic done
);

	// Single-cycle done pulse
	doneOneCycle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
		else $error("done stayed high for more than one cycle");

	// Core is back in idle when done shows
	doneNotBusy: assert property (@(posedge clk) disable iff (reset) done |-> !busy)
		else $error("busy high while done is high");

	// At most one load strobe per cycle
	strobesExclusive: assert property (@(posedge clk) disable iff (reset)
		$onehot0({latchInstr, latchOperands, latchResult, commit}))
		else $error("more than one sequencer strobe active");

endmodule

`default_nettype wire

// File: rtl/cpuCore.sv
// Multicycle execute core top level
// Holds pc and the stage registers, writes back on commit
`timescale 1ns/1ps
`default_nettype none

module cpuCore
	import isaPkg::*;
	import corePkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        start,
	input  logic [15:0] instr,
	output logic [15:0] pc,
	output logic        busy,
	output logic        done,
	output logic        wbEn,
	output logic [2:0]  wbReg,
	output logic [15:0] wbData
);

	logic        latchInstr;
	logic        latchOperands;
	logic        latchResult;
	logic        commit;
	instrWord    instrReg;
	ctrlBundle   ctrl;
	logic [15:0] regA;
	logic [15:0] regB;
	logic [15:0] opA;
	logic [15:0] opB;
	logic [15:0] pcPlus2;
	execResult   exec;
	execResult   resReg;

	coreSequencer sequencer (
		.clk(clk),
		.reset(reset),
		.start(start),
		.latchInstr(latchInstr),
		.latchOperands(latchOperands),
		.latchResult(latchResult),
		.commit(commit),
		.busy(busy),
		.done(done)
	);

	controlDecode decoder (
		.instr(instrReg),
		.ctrl(ctrl)
	);

	// Write port fires only on the commit edge
	registerFile regFile (
		.clk(clk),
		.reset(reset),
		.readA(instrReg.rs),
		.readB(instrReg.rt),
		.dataA(regA),
		.dataB(regB),
		.writeEn(commit && resReg.writeEn),
		.writeAddr(resReg.writeReg),
		.writeData(resReg.result)
	);

	// pc holds still until commit
	assign pcPlus2 = pc + 16'd2;

	executeInstruction execute (
		.instr(instrReg),
		.ctrl(ctrl),
		.a(opA),
		.b(opB),
		.pcPlus2(pcPlus2),
		.res(exec)
	);

	// Stage registers
	always_ff @(posedge clk) begin
		if (latchInstr) begin
			instrReg <= instr;
		end
		if (latchOperands) begin
			opA <= regA;
			opB <= regB;
		end
		if (latchResult) begin
			resReg <= exec;
		end
		// Writeback view, valid while done is high
		if (commit) begin
			wbReg <= resReg.writeReg;
			wbData <= resReg.result;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= 16'h0000;
			wbEn <= 1'b0;
		end else begin
			wbEn <= commit && resReg.writeEn;
			if (commit) begin
				pc <= resReg.nextPc;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/coreSequencer.sv
// Instruction sequencer
// Steps idle, decode, execute, writeback with one load strobe per step
`timescale 1ns/1ps
`default_nettype none

module coreSequencer
	import corePkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic start,
	output logic latchInstr,
	output logic latchOperands,
	output logic latchResult,
	output logic commit,
	output logic busy,
	output logic done
);

	seqState state;
	seqState nextState;

	// Start only counts in idle
	assign latchInstr = (state == seqIdle) && start;
	assign latchOperands = (state == seqDecode);
	assign latchResult = (state == seqExecute);
	assign commit = (state == seqWriteback);
	assign busy = (state != seqIdle);

	always_comb begin
		case (state)
			seqIdle:    nextState = start ? seqDecode : seqIdle;
			seqDecode:  nextState = seqExecute;
			seqExecute: nextState = seqWriteback;
			default:    nextState = seqIdle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= seqIdle;
			done <= 1'b0;
		end else begin
			state <= nextState;
			// Pulse in the cycle after the commit edge
			done <= commit;
		end
	end

endmodule

`default_nettype wire

// File: rtl/registerFile.sv
// Eight 16-bit registers
// Two combinational read ports and one synchronous write port
`timescale 1ns/1ps
`default_nettype none

module registerFile (
	input  logic        clk,
	input  logic        reset,
	input  logic [2:0]  readA,
	input  logic [2:0]  readB,
	output logic [15:0] dataA,
	output logic [15:0] dataB,
	input  logic        writeEn,
	input  logic [2:0]  writeAddr,
	input  logic [15:0] writeData
);

	logic [15:0] regs [8];

	// R0 is an ordinary register
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= 16'h0000;
			end
		end else if (writeEn) begin
			regs[writeAddr] <= writeData;
		end
	end

	assign dataA = regs[readA];
	assign dataB = regs[readB];

endmodule

`default_nettype wire

// File: rtl/executeInstruction.sv
// Execute stage
// Picks operands and immediate, runs the ALU, resolves branches and jumps
`timescale 1ns/1ps
`default_nettype none

module executeInstruction
	import isaPkg::*;
	import corePkg::*;
(
	input  instrWord    instr,
	input  ctrlBundle   ctrl,
	input  logic [15:0] a,
	input  logic [15:0] b,
	input  logic [15:0] pcPlus2,
	output execResult   res
);

	logic [15:0] raw;
	logic [15:0] zext5;
	logic [15:0] zext8;
	logic [15:0] sext5;
	logic [15:0] sext8;
	logic [15:0] sext11;
	logic [15:0] imm;
	logic [15:0] aluB;
	logic [15:0] aluResult;
	logic        zeroFlag;
	logic        posFlag;
	logic        negFlag;
	logic        branchTaken;
	logic [15:0] pcOffset;

	// Immediates are cut from the flat word
	assign raw = instr;
	assign zext5 = {11'b0, raw[4:0]};
	assign zext8 = {8'b0, raw[7:0]};
	assign sext5 = {{11{raw[4]}}, raw[4:0]};
	assign sext8 = {{8{raw[7]}}, raw[7:0]};
	assign sext11 = {{5{raw[10]}}, raw[10:0]};

	always_comb begin
		casez (ctrl.immSel)
			3'b000:  imm = zext5;
			3'b001:  imm = zext8;
			3'b01?:  imm = sext5;
			3'b10?:  imm = sext8;
			default: imm = sext11;
		endcase
	end

	// Zero for branches so the flags reflect Rs alone
	assign aluB = ctrl.branching ? 16'h0000 : (ctrl.aluSrcReg ? b : imm);

	alu mainAlu (
		.a(a),
		.b(aluB),
		.cin(ctrl.cin),
		.invA(ctrl.invA),
		.invB(ctrl.invB),
		.op(ctrl.aluOp),
		.result(aluResult),
		.zero(zeroFlag),
		.pos(posFlag),
		.neg(negFlag)
	);

	// Condition in the low opcode bits, BEQZ BNEZ BLTZ BGEZ
	always_comb begin
		case (instr.opcode[1:0])
			2'b00:   branchTaken = zeroFlag;
			2'b01:   branchTaken = !zeroFlag;
			2'b10:   branchTaken = negFlag;
			default: branchTaken = zeroFlag || posFlag;
		endcase
		branchTaken = branchTaken && ctrl.branching;
	end

	// Same immediate serves jumps and taken branches
	assign pcOffset = (ctrl.jumpImm || branchTaken) ? imm : 16'h0000;

	always_comb begin
		res.nextPc = ctrl.jumpReg ? (a + sext8) : (pcPlus2 + pcOffset);
		// Link jumps return to the instruction after the jump
		res.result = ctrl.linkR7 ? pcPlus2 : aluResult;
		res.writeEn = ctrl.regWrite;
		case (ctrl.regDst)
			dstRd:   res.writeReg = instr.rd;
			dstRt:   res.writeReg = instr.rt;
			dstRs:   res.writeReg = instr.rs;
			default: res.writeReg = 3'd7;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/alu.sv
// 16-bit ALU
// Optional operand inversion, then add with carry, xor, and, or pass b
`timescale 1ns/1ps
`default_nettype none

module alu
	import isaPkg::*;
(
	input  logic [15:0] a,
	input  logic [15:0] b,
	input  logic        cin,
	input  logic        invA,
	input  logic        invB,
	input  aluOpType    op,
	output logic [15:0] result,
	output logic        zero,
	output logic        pos,
	output logic        neg
);

	logic [15:0] opA;
	logic [15:0] opB;

	// Inversion happens before every operation
	assign opA = invA ? ~a : a;
	assign opB = invB ? ~b : b;

	always_comb begin
		case (op)
			aluAdd:   result = opA + opB + {15'b0, cin};
			aluXor:   result = opA ^ opB;
			// ANDN comes from invB on top of the plain and
			aluAnd:   result = opA & opB;
			default:  result = opB;
		endcase
	end

	// Flags describe the result as a signed value
	assign zero = (result == 16'h0000);
	assign neg = result[15];
	assign pos = !zero && !result[15];

endmodule

`default_nettype wire

// File: rtl/controlDecode.sv
// Instruction decoder
// Maps opcode and funct onto the control bundle, unknown opcodes act as NOP
`timescale 1ns/1ps
`default_nettype none

module controlDecode
	import isaPkg::*;
	import corePkg::*;
(
	input  instrWord  instr,
	output ctrlBundle ctrl
);

	always_comb begin
		// NOP defaults, no write, no pc change beyond pc+2
		ctrl = '0;
		ctrl.regDst = dstRd;
		ctrl.immSel = immZext5;
		ctrl.aluOp = aluAdd;

		case (instr.opcode)
			opAddi: begin
				ctrl.regDst = dstRt;
				ctrl.immSel = immSext5;
				ctrl.regWrite = 1'b1;
			end
			opSubi: begin
				// imm - Rs as ~Rs + imm + 1
				ctrl.regDst = dstRt;
				ctrl.immSel = immSext5;
				ctrl.invA = 1'b1;
				ctrl.cin = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			opXori: begin
				ctrl.regDst = dstRt;
				ctrl.immSel = immZext5;
				ctrl.aluOp = aluXor;
				ctrl.regWrite = 1'b1;
			end
			opAndni: begin
				ctrl.regDst = dstRt;
				ctrl.immSel = immZext5;
				ctrl.aluOp = aluAnd;
				ctrl.invB = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			opBeqz, opBnez, opBltz, opBgez: begin
				ctrl.immSel = immSext8;
				ctrl.branching = 1'b1;
			end
			opLbi: begin
				ctrl.regDst = dstRs;
				ctrl.immSel = immSext8;
				ctrl.aluOp = aluPassB;
				ctrl.regWrite = 1'b1;
			end
			opRType: begin
				ctrl.regDst = dstRd;
				ctrl.aluSrcReg = 1'b1;
				ctrl.regWrite = 1'b1;
				case (instr.funct)
					functSub: begin
						// Rt - Rs
						ctrl.invA = 1'b1;
						ctrl.cin = 1'b1;
					end
					functXor: ctrl.aluOp = aluXor;
					functAndn: begin
						ctrl.aluOp = aluAnd;
						ctrl.invB = 1'b1;
					end
					default: ctrl.aluOp = aluAdd;
				endcase
			end
			opJ: begin
				ctrl.immSel = immSext11;
				ctrl.jumpImm = 1'b1;
			end
			opJal: begin
				ctrl.immSel = immSext11;
				ctrl.jumpImm = 1'b1;
				ctrl.regDst = dstR7;
				ctrl.linkR7 = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			opJr: ctrl.jumpReg = 1'b1;
			opJalr: begin
				ctrl.jumpReg = 1'b1;
				ctrl.regDst = dstR7;
				ctrl.linkR7 = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			default: begin
				// NOP and unsupported opcodes keep the defaults
			end
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/corePkg.sv
// Core-internal types
// Control bundle, execute result and sequencer states
`default_nettype none

package corePkg;

	import isaPkg::*;

	// Decoded control for one instruction
	typedef struct packed {
		regDstSel  regDst;
		immSelType immSel;
		// Second ALU operand from Rt instead of the immediate
		logic      aluSrcReg;
		logic      invA;
		logic      invB;
		logic      cin;
		aluOpType  aluOp;
		// Branch on Rs, second operand forced to zero
		logic      branching;
		// pc+2 plus immediate
		logic      jumpImm;
		// Rs plus sign-extended 8
		logic      jumpReg;
		// Write pc+2 into R7
		logic      linkR7;
		logic      regWrite;
	} ctrlBundle;

	// Everything writeback needs
	typedef struct packed {
		logic [15:0] result;
		logic [15:0] nextPc;
		logic [2:0]  writeReg;
		logic        writeEn;
	} execResult;

	// One state per instruction phase
	typedef enum logic [1:0] {
		seqIdle      = 2'b00,
		seqDecode    = 2'b01,
		seqExecute   = 2'b10,
		seqWriteback = 2'b11
	} seqState;

endpackage

`default_nettype wire

// File: rtl/isaPkg.sv
// ISA definitions for the 16-bit teaching core
// Opcode and funct encodings, instruction fields and decode select codes
`default_nettype none

package isaPkg;

	// Supported opcodes, anything else decodes as NOP
	typedef enum logic [4:0] {
		opNop   = 5'b00001,
		opJ     = 5'b00100,
		opJr    = 5'b00101,
		opJal   = 5'b00110,
		opJalr  = 5'b00111,
		opAddi  = 5'b01000,
		opSubi  = 5'b01001,
		opXori  = 5'b01010,
		opAndni = 5'b01011,
		opBeqz  = 5'b01100,
		opBnez  = 5'b01101,
		opBltz  = 5'b01110,
		opBgez  = 5'b01111,
		opLbi   = 5'b11000,
		opRType = 5'b11011
	} opcodeType;

	// Register group operation in the low two bits
	typedef enum logic [1:0] {
		functAdd  = 2'b00,
		functSub  = 2'b01,
		functXor  = 2'b10,
		functAndn = 2'b11
	} functType;

	// Field view of one instruction word, immediates overlap the low fields
	typedef struct packed {
		logic [4:0] opcode;
		logic [2:0] rs;
		logic [2:0] rt;
		logic [2:0] rd;
		logic [1:0] funct;
	} instrWord;

	// Destination register select
	typedef enum logic [1:0] {
		dstRd = 2'b00,
		dstRt = 2'b01,
		dstRs = 2'b10,
		dstR7 = 2'b11
	} regDstSel;

	// Immediate select, low bit is a don't care for the signed forms
	typedef enum logic [2:0] {
		immZext5  = 3'b000,
		immZext8  = 3'b001,
		immSext5  = 3'b010,
		immSext8  = 3'b100,
		immSext11 = 3'b110
	} immSelType;

	// ALU operation after optional operand inversion
	typedef enum logic [1:0] {
		aluAdd   = 2'b00,
		aluXor   = 2'b01,
		aluAnd   = 2'b10,
		aluPassB = 2'b11
	} aluOpType;

endpackage

`default_nettype wire
